// ==== logic/frame_stats_defines.svh ====
`ifndef FRAME_STATS_DEFINES_SVH
`define FRAME_STATS_DEFINES_SVH

// --------------------
// Frame geometry
// --------------------
`define FRAME_ROWS 45
`define FRAME_COLS 45

// Tag carried alongside every frame and result
`define TAG_W 8

// --------------------
// Buffer sizing
// --------------------
`define IN_FIFO_DEPTH  8   // Power of two
`define OUT_FIFO_DEPTH 4   // Power of two, also the credit limit

`endif

// ==== logic/frame_pkg.sv ====
`default_nettype none

`include "frame_stats_defines.svh"

package frame_pkg;

  // Bits in one bitmap
  localparam int FRAME_BITS = `FRAME_ROWS * `FRAME_COLS;

  // Row r sits in data[r*FRAME_COLS +: FRAME_COLS]
  typedef struct packed {
    logic [`TAG_W-1:0]     tag;
    logic [FRAME_BITS-1:0] data;
  } frame_t;

  // Level flags of one FIFO
  typedef struct packed {
    logic empty;
    logic almost_empty;  // Exactly one entry
    logic almost_full;   // One slot left
    logic full;
  } fifo_flags_t;

endpackage

`default_nettype wire

// ==== logic/stats_pkg.sv ====
`default_nettype none

`include "frame_stats_defines.svh"

package stats_pkg;

  // --------------------
  // Field widths
  // --------------------
  localparam int ROW_CNT_W = $clog2(`FRAME_COLS + 1);              // 0 to 45
  localparam int ZROW_W    = $clog2(`FRAME_ROWS + 1);              // 0 to 45
  localparam int ONES_W    = $clog2(`FRAME_ROWS * `FRAME_COLS) + 1; // One spare bit

  // Ones in a single row
  typedef logic [ROW_CNT_W-1:0] row_count_t;

  typedef struct packed {
    logic [`TAG_W-1:0] tag;
    logic [ONES_W-1:0] ones;       // Set cells in the frame
    logic [ZROW_W-1:0] zero_rows;  // Rows without any set cell
    logic              parity;     // XOR of all cells
  } stats_t;

endpackage

`default_nettype wire

// ==== logic/frame_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_fifo #(
  parameter type         T_PAYLOAD = logic [7:0],
  parameter int unsigned DEPTH     = 4
) (
  input  wire logic               clk,
  input  wire logic               rst_n,

  input  wire T_PAYLOAD           data_i,
  input  wire logic               wr_valid_i,
  input  wire logic               rd_valid_i,

  output T_PAYLOAD                data_o,
  output frame_pkg::fifo_flags_t  flags_o
);

  localparam int ADDR_W = $clog2(DEPTH);

  // --------------------
  // Storage and pointers
  // --------------------
  T_PAYLOAD          mem [DEPTH];
  logic [ADDR_W:0]   wr_ptr;        // Top bit is the wrap flag
  logic [ADDR_W:0]   rd_ptr;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W:0]   fill;          // Entries stored

  logic empty;
  logic full;
  logic do_write;
  logic do_read;

  assign wr_addr = wr_ptr[ADDR_W-1:0];
  assign rd_addr = rd_ptr[ADDR_W-1:0];
  assign fill    = wr_ptr - rd_ptr;

  // --------------------
  // Level flags
  // --------------------
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_addr == rd_addr) && (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]);

  assign flags_o.empty        = empty;
  assign flags_o.almost_empty = (fill == 1);
  assign flags_o.almost_full  = (fill == DEPTH - 1);
  assign flags_o.full         = full;

  // Strobes only count when the FIFO can take them
  assign do_write = wr_valid_i && !full;
  assign do_read  = rd_valid_i && !empty;

  // Head shown without a read delay
  assign data_o = mem[rd_addr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (do_write) begin
      mem[wr_addr] <= data_i;
    end
  end

  // --------------------
  // Pointer update
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_write) begin
      wr_ptr <= wr_ptr + 1'b1;  // Wraps into the top bit
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_read) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/stats_issue_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "frame_stats_defines.svh"

module stats_issue_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,

  input  wire logic in_empty_i,  // Input FIFO has nothing to issue
  input  wire logic pop_i,       // Accepted pop from the output FIFO

  output logic      issue_o      // Pop input FIFO, start the pipeline
);

  // Counter has to reach OUT_FIFO_DEPTH itself
  localparam int CREDIT_W = $clog2(`OUT_FIFO_DEPTH + 1);

  // --------------------
  // Credit state
  // --------------------
  // Results issued but not yet popped, in flight or stored
  logic [CREDIT_W-1:0] reserved_q;
  logic [CREDIT_W-1:0] reserved_d;
  logic                has_credit;

  assign has_credit = (reserved_q < `OUT_FIFO_DEPTH);

  // Out FIFO can never overflow while this holds
  assign issue_o = !in_empty_i && has_credit;

  // --------------------
  // Counter update
  // --------------------
  always_comb begin
    reserved_d = reserved_q;
    case ({issue_o, pop_i})
      2'b10:   reserved_d = reserved_q + 1'b1;  // New frame claims a slot
      2'b01:   reserved_d = reserved_q - 1'b1;  // Consumer freed a slot
      default: reserved_d = reserved_q;         // Both or neither cancel out
    endcase
  end

  // A pop always refers to a reserved result, so no underflow
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reserved_q <= '0;
    end else begin
      reserved_q <= reserved_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/frame_stats_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "frame_stats_defines.svh"

module frame_stats_unit (
  input  wire logic               clk,
  input  wire logic               rst_n,

  input  wire logic               in_valid_i,
  input  wire frame_pkg::frame_t  frame_i,

  output logic                    out_valid_o,  // Single-cycle write strobe
  output stats_pkg::stats_t       stats_o
);

  // Popcount of one row
  function automatic stats_pkg::row_count_t count_row(input logic [`FRAME_COLS-1:0] row);
    stats_pkg::row_count_t cnt;
    cnt = '0;
    for (int c = 0; c < `FRAME_COLS; c++) begin
      cnt = cnt + row[c];
    end
    return cnt;
  endfunction

  // --------------------
  // Stage 1 row counts
  // --------------------
  stats_pkg::row_count_t row_cnt_q [`FRAME_ROWS];
  logic [`TAG_W-1:0]     tag_q;
  logic                  valid_s1_q;

  always_ff @(posedge clk) begin
    if (in_valid_i) begin
      for (int r = 0; r < `FRAME_ROWS; r++) begin
        row_cnt_q[r] <= count_row(frame_i.data[r*`FRAME_COLS +: `FRAME_COLS]);
      end
      tag_q <= frame_i.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_s1_q <= 1'b0;
    end else begin
      valid_s1_q <= in_valid_i;
    end
  end

  // --------------------
  // Stage 2 totals
  // --------------------
  logic [stats_pkg::ONES_W-1:0] ones_sum;
  logic [stats_pkg::ZROW_W-1:0] zero_sum;

  always_comb begin
    ones_sum = '0;
    zero_sum = '0;
    for (int r = 0; r < `FRAME_ROWS; r++) begin
      ones_sum = ones_sum + row_cnt_q[r];
      zero_sum = zero_sum + (row_cnt_q[r] == '0);  // Empty row
    end
  end

  always_ff @(posedge clk) begin
    if (valid_s1_q) begin
      stats_o.tag       <= tag_q;
      stats_o.ones      <= ones_sum;
      stats_o.zero_rows <= zero_sum;
      stats_o.parity    <= ones_sum[0];  // Odd count means odd parity
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= valid_s1_q;
    end
  end

endmodule

`default_nettype wire

// ==== logic/frame_stats_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "frame_stats_defines.svh"

module frame_stats_top (
  input  wire logic               clk,
  input  wire logic               rst_n,

  // Producer side
  input  wire frame_pkg::frame_t  frame_i,
  input  wire logic               frame_wr_i,
  output frame_pkg::fifo_flags_t  in_flags_o,

  // Consumer side
  input  wire logic               stats_rd_i,
  output stats_pkg::stats_t       stats_o,
  output frame_pkg::fifo_flags_t  out_flags_o
);

  // --------------------
  // Internal wires
  // --------------------
  frame_pkg::frame_t in_head;     // Head of the input FIFO
  logic              issue;       // Pop input FIFO, feed the pipeline
  logic              pop;         // Accepted consumer read
  logic              unit_valid;
  stats_pkg::stats_t unit_stats;

  // Only a read of a non-empty FIFO returns a credit
  assign pop = stats_rd_i & ~out_flags_o.empty;

  // --------------------
  // Input buffer
  // --------------------
  frame_fifo #(
    .T_PAYLOAD (frame_pkg::frame_t),
    .DEPTH     (`IN_FIFO_DEPTH)
  ) u_in_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_i     (frame_i),
    .wr_valid_i (frame_wr_i),
    .rd_valid_i (issue),
    .data_o     (in_head),
    .flags_o    (in_flags_o)
  );

  stats_issue_ctrl u_issue_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_empty_i (in_flags_o.empty),
    .pop_i      (pop),
    .issue_o    (issue)
  );

  // Samples the head on the same edge that pops it
  frame_stats_unit u_stats_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (issue),
    .frame_i     (in_head),
    .out_valid_o (unit_valid),
    .stats_o     (unit_stats)
  );

  // --------------------
  // Result buffer
  // --------------------
  frame_fifo #(
    .T_PAYLOAD (stats_pkg::stats_t),
    .DEPTH     (`OUT_FIFO_DEPTH)
  ) u_out_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_i     (unit_stats),
    .wr_valid_i (unit_valid),
    .rd_valid_i (stats_rd_i),
    .data_o     (stats_o),
    .flags_o    (out_flags_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_frame_stats_checks.svh ====
`ifndef TB_FRAME_STATS_CHECKS_SVH
`define TB_FRAME_STATS_CHECKS_SVH

// Ends the run at the first error
task automatic stop_on_error();
  $display("Test failed");
  $fatal(1, "Simulation stopped at the first error");
endtask

// --------------------
// Result compares
// --------------------
task automatic check_stats(input stats_pkg::stats_t got, input stats_pkg::stats_t exp);
  string field;
  field = "";
  if (got.tag != exp.tag) field = "tag";
  else if (got.ones != exp.ones) field = "ones";
  else if (got.zero_rows != exp.zero_rows) field = "zero_rows";
  else if (got.parity != exp.parity) field = "parity";
  if (field != "") begin
    $display("[FAIL] %0t: stats.%s got tag %0h ones %0d zero_rows %0d parity %0b", $time,
             field, got.tag, got.ones, got.zero_rows, got.parity);
    $display("  expected tag %0h ones %0d zero_rows %0d parity %0b",
             exp.tag, exp.ones, exp.zero_rows, exp.parity);
    stop_on_error();
  end
endtask

task automatic check_flags(input frame_pkg::fifo_flags_t got,
                           input frame_pkg::fifo_flags_t exp, input string which);
  string field;
  field = "";
  if (got.empty != exp.empty) field = "empty";
  else if (got.almost_empty != exp.almost_empty) field = "almost_empty";
  else if (got.almost_full != exp.almost_full) field = "almost_full";
  else if (got.full != exp.full) field = "full";
  if (field != "") begin
    $display("[FAIL] %0t: %s.%s got %b expected %b (flags e/ae/af/f)", $time,
             which, field, got, exp);
    stop_on_error();
  end
endtask

// Cycle counts such as the frame latency
task automatic check_count(input int got, input int exp, input string what);
  if (got != exp) begin
    $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
    stop_on_error();
  end
endtask

`endif

// ==== test/tb_frame_stats.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "frame_stats_defines.svh"

module tb_frame_stats;

  localparam int IN_DEPTH      = `IN_FIFO_DEPTH;
  localparam int OUT_DEPTH     = `OUT_FIFO_DEPTH;
  localparam int WAIT_LIMIT    = 50;    // Cycles for a single wait
  localparam int TRAFFIC_LIMIT = 2000;

  logic                   clk;
  logic                   rst_n;
  frame_pkg::frame_t      frame_in;
  logic                   frame_wr;
  frame_pkg::fifo_flags_t in_flags;
  logic                   stats_rd;
  stats_pkg::stats_t      stats_out;
  frame_pkg::fifo_flags_t out_flags;

  stats_pkg::stats_t exp_q[$];  // Results in write order
  int unsigned       seed_val;

  `include "tb_frame_stats_checks.svh"

  frame_stats_top DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_i     (frame_in),
    .frame_wr_i  (frame_wr),
    .in_flags_o  (in_flags),
    .stats_rd_i  (stats_rd),
    .stats_o     (stats_out),
    .out_flags_o (out_flags)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic stats_pkg::stats_t model_stats(input frame_pkg::frame_t f);
    stats_pkg::stats_t s;
    int ones;
    int zrows;
    bit row_has_one;
    ones  = 0;
    zrows = 0;
    for (int r = 0; r < `FRAME_ROWS; r++) begin
      row_has_one = 1'b0;
      for (int c = 0; c < `FRAME_COLS; c++) begin
        if (f.data[r*`FRAME_COLS + c]) begin
          ones++;
          row_has_one = 1'b1;
        end
      end
      if (!row_has_one) zrows++;
    end
    s.tag       = f.tag;
    s.ones      = ones;
    s.zero_rows = zrows;
    s.parity    = ^f.data;
    return s;
  endfunction

  function automatic frame_pkg::fifo_flags_t flags_for(input int count, input int depth);
    frame_pkg::fifo_flags_t fl;
    fl.empty        = (count == 0);
    fl.almost_empty = (count == 1);
    fl.almost_full  = (count == depth - 1);
    fl.full         = (count == depth);
    return fl;
  endfunction

  function automatic frame_pkg::frame_t random_frame(input logic [`TAG_W-1:0] tag);
    frame_pkg::frame_t f;
    logic [31:0]       word;
    f.tag  = tag;
    f.data = '0;
    for (int b = 0; b < frame_pkg::FRAME_BITS; b += 32) begin
      word = $urandom;
      for (int k = 0; k < 32; k++) begin
        if (b + k < frame_pkg::FRAME_BITS) f.data[b + k] = word[k];
      end
    end
    // Blank some rows so zero_rows moves around
    for (int r = 0; r < `FRAME_ROWS; r++) begin
      if ($urandom_range(3) == 0) f.data[r*`FRAME_COLS +: `FRAME_COLS] = '0;
    end
    return f;
  endfunction

  // --------------------
  // Drivers
  // --------------------
  task automatic write_frame(input frame_pkg::frame_t f);
    if (!in_flags.full) exp_q.push_back(model_stats(f));  // Dropped when full
    frame_in = f;
    frame_wr = 1'b1;
    @(negedge clk);
    frame_wr = 1'b0;
  endtask

  // Head must be accounted for by the model before it is popped
  task automatic check_head();
    if (exp_q.size() == 0) begin
      $display("Output FIFO holds a result that no accepted frame accounts for");
      stop_on_error();
    end else begin
      check_stats(stats_out, exp_q.pop_front());
    end
  endtask

  task automatic wait_out_flags(input frame_pkg::fifo_flags_t want, input string what);
    int cycles;
    cycles = 0;
    while (out_flags != want) begin
      if (cycles >= WAIT_LIMIT) begin
        $display("Timed out after %0d cycles waiting for %s", cycles, what);
        stop_on_error();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic check_idle();
    frame_wr = 1'b0;
    stats_rd = 1'b0;
    repeat (4) @(negedge clk);  // Longer than the pipeline
    check_flags(in_flags, flags_for(0, IN_DEPTH), "in_flags");
    check_flags(out_flags, flags_for(0, OUT_DEPTH), "out_flags");
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_single_frame(input frame_pkg::frame_t f, input string name);
    int lat;
    write_frame(f);
    lat = 0;  // Edges since the write edge
    while (out_flags.empty) begin
      if (lat >= WAIT_LIMIT) begin
        $display("Timed out waiting for the result of the %s frame", name);
        stop_on_error();
      end
      @(negedge clk);
      lat++;
    end
    check_count(lat, 3, {name, " frame latency"});
    check_flags(out_flags, flags_for(1, OUT_DEPTH), "out_flags");
    check_head();
    stats_rd = 1'b1;
    @(negedge clk);
    stats_rd = 1'b0;
    check_flags(out_flags, flags_for(0, OUT_DEPTH), "out_flags");
  endtask

  task automatic test_single_frames();
    frame_pkg::frame_t f;
    stats_pkg::stats_t full_stats;
    f.tag  = 8'h01;
    f.data = '0;
    test_single_frame(f, "all-zero");
    f.tag  = 8'h02;
    f.data = '1;
    full_stats.tag       = 8'h02;
    full_stats.ones      = 2025;
    full_stats.zero_rows = 0;
    full_stats.parity    = 1'b1;
    check_stats(model_stats(f), full_stats);
    test_single_frame(f, "all-ones");
    f.tag  = 8'h03;
    f.data = '0;
    f.data[0 +: `FRAME_COLS] = '1;
    test_single_frame(f, "row-0");
  endtask

  task automatic run_traffic(input int n_frames, input bit random_strobes, input string name);
    frame_pkg::frame_t f;
    int written;
    int cycles;
    bit do_wr;
    bit do_rd;
    written = 0;
    cycles  = 0;
    f = random_frame(8'($urandom));
    while (written < n_frames || exp_q.size() > 0) begin
      if (cycles >= TRAFFIC_LIMIT) begin
        $display("Timed out in %s traffic with %0d results outstanding", name, exp_q.size());
        stop_on_error();
      end
      do_wr = (written < n_frames) && (!random_strobes || $urandom_range(1) == 1);
      do_rd = !random_strobes || ($urandom_range(2) != 0);
      if (do_rd && !out_flags.empty) check_head();
      frame_in = f;
      frame_wr = do_wr;
      stats_rd = do_rd;
      if (do_wr && !in_flags.full) begin
        exp_q.push_back(model_stats(f));
        written++;
        f = random_frame(8'($urandom));  // Next one, frame_in already holds this
      end
      @(negedge clk);
      cycles++;
    end
    frame_wr = 1'b0;
    stats_rd = 1'b0;
    check_idle();
  endtask

  task automatic test_back_pressure();
    logic [`TAG_W-1:0] drop_tag;
    int popped;
    int cycles;
    drop_tag = 8'hff;
    for (int k = 1; k <= OUT_DEPTH; k++) begin
      write_frame(random_frame(8'(8'h10 + k)));
      wait_out_flags(flags_for(k, OUT_DEPTH), "output FIFO level under back-pressure");
    end
    for (int m = 1; m <= IN_DEPTH; m++) begin  // Credits are gone, frames stay put
      write_frame(random_frame(8'(8'h20 + m)));
      check_flags(in_flags, flags_for(m, IN_DEPTH), "in_flags");
    end
    check_flags(out_flags, flags_for(OUT_DEPTH, OUT_DEPTH), "out_flags");
    write_frame(random_frame(drop_tag));
    check_flags(in_flags, flags_for(IN_DEPTH, IN_DEPTH), "in_flags");

    // Drain everything
    popped = 0;
    cycles = 0;
    while (exp_q.size() > 0) begin
      if (cycles >= TRAFFIC_LIMIT) begin
        $display("Timed out draining, %0d results popped so far", popped);
        stop_on_error();
      end
      stats_rd = !out_flags.empty;
      if (!out_flags.empty) begin
        if (stats_out.tag == drop_tag) begin
          $display("[FAIL] %0t: tag %0h of the dropped frame came out", $time, drop_tag);
          stop_on_error();
        end
        check_head();
        popped++;
      end
      @(negedge clk);
      cycles++;
    end
    stats_rd = 1'b0;
    check_idle();
  endtask

  initial begin
    seed_val = $urandom(32'he32567b5);
    rst_n    = 1'b0;
    frame_in = '0;
    frame_wr = 1'b0;
    stats_rd = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_flags(in_flags, flags_for(0, IN_DEPTH), "in_flags");
    check_flags(out_flags, flags_for(0, OUT_DEPTH), "out_flags");
    test_single_frames();
    run_traffic(12, 1'b0, "burst");
    test_back_pressure();
    run_traffic(30, 1'b1, "interleaved");

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
+incdir+test
logic/frame_pkg.sv
logic/stats_pkg.sv
logic/frame_fifo.sv
logic/stats_issue_ctrl.sv
logic/frame_stats_unit.sv
logic/frame_stats_top.sv
test/tb_frame_stats.sv

// ==== Bender.yml ====
package:
  name: frame_stats

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/frame_pkg.sv
      - logic/stats_pkg.sv
      - logic/frame_fifo.sv
      - logic/stats_issue_ctrl.sv
      - logic/frame_stats_unit.sv
      - logic/frame_stats_top.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/tb_frame_stats.sv
